// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module i2c_bridge_tb \
		-f flist.f -o i2c_bridge_sim
	@out=$$(./obj_dir/i2c_bridge_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== dv/i2c_bridge_tb.sv ====
`timescale 1ns/1ps

module i2c_bridge_tb;

	localparam int HALF = 40;          // Clocks per SCL half-period
	localparam int TIMEOUT = 20000;
	localparam logic [6:0] OWN_ADDR = 7'h3a;
	localparam int WSTOP = 0;          // Pulse counter slots
	localparam int RSTOP = 1;
	localparam int RERR = 2;

	logic        clk;
	logic        rst;
	logic        scl_m;
	logic        sda_m;                // Master side, 0 pulls low
	logic        sda_line;
	logic        rx_pop;
	logic        tx_push;
	logic [31:0] tx_data;
	logic        sda_oe;
	logic [31:0] rx_data;
	logic        rx_empty;
	logic        tx_full;
	logic        wstop;
	logic        rstop;
	logic        rerr;
	int          pulse_cnt [3];
	int          oe_hits;              // Cycles with SDA pulled by the slave

	assign sda_line = sda_m && !sda_oe;  // Wired-AND bus

	i2c_bridge_top uut (
		.clk          (clk),
		.rst          (rst),
		.scl_i        (scl_m),
		.sda_i        (sda_line),
		.slave_addr_i (OWN_ADDR),
		.rx_pop_i     (rx_pop),
		.tx_push_i    (tx_push),
		.tx_data_i    (tx_data),
		.sda_oe_o     (sda_oe),
		.rx_data_o    (rx_data),
		.rx_empty_o   (rx_empty),
		.tx_full_o    (tx_full),
		.wstop_o      (wstop),
		.rstop_o      (rstop),
		.rerr_o       (rerr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Status pulse and SDA drive counters
	always @(negedge clk) begin
		if (rst) begin
			pulse_cnt[WSTOP] <= 0;
			pulse_cnt[RSTOP] <= 0;
			pulse_cnt[RERR]  <= 0;
			oe_hits          <= 0;
		end else begin
			if (wstop)
				pulse_cnt[WSTOP] <= pulse_cnt[WSTOP] + 1;
			if (rstop)
				pulse_cnt[RSTOP] <= pulse_cnt[RSTOP] + 1;
			if (rerr)
				pulse_cnt[RERR] <= pulse_cnt[RERR] + 1;
			if (sda_oe)
				oe_hits <= oe_hits + 1;
		end
	end

	// ------------------------------------------------------------------------
	// Checks and waits
	// ------------------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Test failed");
		$fatal(1, "timeout");
	endtask

	task automatic wait_clks(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic wait_pulses(input int idx, input int target, input string what);
		int n;
		n = 0;
		while (pulse_cnt[idx] < target) begin
			if (n == TIMEOUT)
				fail_timeout(what);
			else begin
				@(negedge clk);
				n++;
			end
		end
	endtask

	task automatic pop_rx_word(input logic [31:0] exp);
		int n;
		n = 0;
		while (rx_empty) begin
			if (n == TIMEOUT)
				fail_timeout("receive FIFO data");
			else begin
				@(negedge clk);
				n++;
			end
		end
		check_value("rx_data_o", rx_data, exp);
		rx_pop = 1'b1;
		@(negedge clk);
		rx_pop = 1'b0;
	endtask

	task automatic push_tx_word(input logic [31:0] w);
		tx_data = w;
		tx_push = 1'b1;
		@(negedge clk);
		tx_push = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// Bit-level master
	// ------------------------------------------------------------------------
	// SDA moves a quarter into the low phase, sampled mid-high
	task automatic clock_bit(input logic b, output logic s);
		wait_clks(HALF / 4);
		sda_m = b;
		wait_clks(HALF - HALF / 4);
		scl_m = 1'b1;
		wait_clks(HALF / 2);
		s = sda_line;
		wait_clks(HALF / 2);
		scl_m = 1'b0;
	endtask

	task automatic bus_start();
		wait_clks(HALF / 4);
		sda_m = 1'b1;
		wait_clks(HALF - HALF / 4);
		scl_m = 1'b1;
		wait_clks(HALF);
		sda_m = 1'b0;          // Start
		wait_clks(HALF);
		scl_m = 1'b0;
	endtask

	task automatic bus_stop();
		wait_clks(HALF / 4);
		sda_m = 1'b0;
		wait_clks(HALF - HALF / 4);
		scl_m = 1'b1;
		wait_clks(HALF);
		sda_m = 1'b1;          // Stop
		wait_clks(HALF);
	endtask

	task automatic write_byte(input logic [7:0] d, output logic ack);
		logic s;
		for (int i = 7; i >= 0; i--)
			clock_bit(d[i], s);
		clock_bit(1'b1, ack);  // Release for the slave ACK
	endtask

	task automatic read_byte(input logic last, output logic [7:0] d);
		logic s;
		d = '0;
		for (int i = 0; i < 8; i++) begin
			clock_bit(1'b1, s);
			d = {d[6:0], s};
		end
		clock_bit(last, s);    // NACK on the last byte
	endtask

	// ------------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------------
	task automatic test_reset_state();
		check_value("sda_oe_o", 32'(sda_oe), 0);
		check_value("wstop_o", 32'(wstop), 0);
		check_value("rstop_o", 32'(rstop), 0);
		check_value("rerr_o", 32'(rerr), 0);
		check_value("rx_empty_o", 32'(rx_empty), 1);
		check_value("tx_full_o", 32'(tx_full), 0);
	endtask

	task automatic test_write_words();
		logic [31:0] w [2];
		logic        ack;
		int          base;
		w[0] = $urandom;
		w[1] = $urandom;
		base = pulse_cnt[WSTOP];
		bus_start();
		write_byte({OWN_ADDR, 1'b0}, ack);
		check_value("address ack", 32'(ack), 0);
		for (int i = 0; i < 8; i++) begin
			write_byte(w[i / 4][31 - 8 * (i % 4) -: 8], ack);
			check_value("data ack", 32'(ack), 0);
		end
		bus_stop();
		wait_pulses(WSTOP, base + 1, "wstop_o");
		wait_clks(HALF);
		check_value("wstop_o pulses", pulse_cnt[WSTOP], base + 1);
		pop_rx_word(w[0]);
		pop_rx_word(w[1]);
		check_value("rx_empty_o", 32'(rx_empty), 1);
	endtask

	task automatic test_addr_filter();
		logic [31:0] w;
		logic        ack;
		int          base;
		// Wrong address, a full word follows that the slave ignores
		w = $urandom;
		base = pulse_cnt[WSTOP];
		bus_start();
		write_byte({7'h15, 1'b0}, ack);
		check_value("wrong address ack", 32'(ack), 1);
		for (int i = 0; i < 4; i++) begin
			write_byte(w[31 - 8 * i -: 8], ack);
			check_value("ignored data ack", 32'(ack), 1);
		end
		bus_stop();
		wait_clks(HALF);
		check_value("rx_empty_o", 32'(rx_empty), 1);
		check_value("wstop_o pulses", pulse_cnt[WSTOP], base);
		// General call
		w = $urandom;
		bus_start();
		write_byte(8'h00, ack);
		check_value("general call ack", 32'(ack), 0);
		for (int i = 0; i < 4; i++) begin
			write_byte(w[31 - 8 * i -: 8], ack);
			check_value("data ack", 32'(ack), 0);
		end
		bus_stop();
		wait_pulses(WSTOP, base + 1, "wstop_o");
		pop_rx_word(w);
		// Partial word is dropped
		w = $urandom;
		bus_start();
		write_byte({OWN_ADDR, 1'b0}, ack);
		check_value("address ack", 32'(ack), 0);
		for (int i = 0; i < 3; i++) begin
			write_byte(w[31 - 8 * i -: 8], ack);
			check_value("data ack", 32'(ack), 0);
		end
		bus_stop();
		wait_pulses(WSTOP, base + 2, "wstop_o");
		wait_clks(HALF);
		check_value("rx_empty_o", 32'(rx_empty), 1);
	endtask

	task automatic test_read_words();
		logic [31:0] w [2];
		logic [7:0]  d;
		logic        ack;
		int          base;
		w[0] = $urandom;
		w[1] = $urandom;
		push_tx_word(w[0]);
		push_tx_word(w[1]);
		check_value("tx_full_o", 32'(tx_full), 0);
		base = pulse_cnt[RSTOP];
		bus_start();
		write_byte({OWN_ADDR, 1'b1}, ack);
		check_value("read address ack", 32'(ack), 0);
		for (int i = 0; i < 8; i++) begin
			read_byte(i == 7, d);
			check_value("read byte", 32'(d), 32'(w[i / 4][31 - 8 * (i % 4) -: 8]));
		end
		bus_stop();
		wait_pulses(RSTOP, base + 1, "rstop_o");
		wait_clks(HALF);
		check_value("rstop_o pulses", pulse_cnt[RSTOP], base + 1);
		check_value("tx_full_o", 32'(tx_full), 0);
		// Nothing left to send
		bus_start();
		write_byte({OWN_ADDR, 1'b1}, ack);
		check_value("empty read ack", 32'(ack), 1);
		bus_stop();
	endtask

	task automatic test_read_error();
		logic [31:0] w;
		logic        ack;
		logic        s;
		int          base;
		int          oe_base;
		// Slave releases the first bit and would pull the second
		w = ($urandom | 32'h8000_0000) & 32'hbfff_ffff;
		push_tx_word(w);
		base = pulse_cnt[RERR];
		bus_start();
		write_byte({OWN_ADDR, 1'b1}, ack);
		check_value("read address ack", 32'(ack), 0);
		clock_bit(1'b0, s);            // Master fights the 1
		wait_pulses(RERR, base + 1, "rerr_o");
		oe_base = oe_hits;
		for (int i = 0; i < 8; i++)
			clock_bit(1'b1, s);
		check_value("sda_oe_o high cycles", oe_hits, oe_base);
		check_value("rerr_o pulses", pulse_cnt[RERR], base + 1);
		bus_stop();
	endtask

	initial begin
		void'($urandom(32'h9000));
		rst = 1'b1;
		scl_m = 1'b1;
		sda_m = 1'b1;
		rx_pop = 1'b0;
		tx_push = 1'b0;
		tx_data = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		wait_clks(2);
		test_reset_state();
		test_write_words();
		test_addr_filter();
		test_read_words();
		test_read_error();
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
logic/i2c_bridge_pkg.sv
logic/i2c_bus_if.sv
logic/i2c_pin_sync.sv
logic/i2c_slave_fsm.sv
logic/word_fifo.sv
logic/i2c_bridge_top.sv
dv/i2c_bridge_tb.sv

// ==== include/i2c_bridge_cfg.svh ====
`ifndef I2C_BRIDGE_CFG_SVH
`define I2C_BRIDGE_CFG_SVH

// Data word carried by both FIFOs
`define I2C_WORD_W      32

// Entries per FIFO
`define I2C_FIFO_DEPTH  8

// Equal samples needed before a filtered pin level moves
`define I2C_FILTER_LEN  4

`endif

// ==== logic/i2c_bridge_pkg.sv ====
`include "i2c_bridge_cfg.svh"

package i2c_bridge_pkg;

	// One FIFO entry, four bus bytes MSB first
	typedef logic [`I2C_WORD_W-1:0] word_t;

	// Protocol engine states
	typedef enum logic [2:0] {
		IDLE,       // Bus free or transfer not for us
		ADDR,       // Shifting in the address byte
		ADDR_ACK,   // Driving the address acknowledge
		WR_DATA,    // Shifting in a write byte
		WR_ACK,     // Driving the data acknowledge
		RD_DATA,    // Shifting out a read byte
		RD_ACK      // Sampling the master acknowledge
	} i2c_state_e;

endpackage

// ==== logic/i2c_bridge_top.sv ====
`timescale 1ns/1ps
`include "i2c_bridge_cfg.svh"

module i2c_bridge_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   scl_i,
	input  logic                   sda_i,
	input  logic [6:0]             slave_addr_i,
	input  logic                   rx_pop_i,
	input  logic                   tx_push_i,
	input  i2c_bridge_pkg::word_t  tx_data_i,
	output logic                   sda_oe_o,    // Pull-low enable for SDA
	output i2c_bridge_pkg::word_t  rx_data_o,
	output logic                   rx_empty_o,
	output logic                   tx_full_o,
	output logic                   wstop_o,
	output logic                   rstop_o,
	output logic                   rerr_o
);

	logic                  rx_push;
	i2c_bridge_pkg::word_t rx_word;
	logic                  rx_full;
	logic                  tx_pop;
	i2c_bridge_pkg::word_t tx_word;
	logic                  tx_empty;

	i2c_bus_if bus ();

	i2c_pin_sync u_pin_sync (
		.clk   (clk),
		.rst   (rst),
		.scl_i (scl_i),
		.sda_i (sda_i),
		.bus   (bus)
	);

	i2c_slave_fsm u_fsm (
		.clk          (clk),
		.rst          (rst),
		.slave_addr_i (slave_addr_i),
		.rx_full_i    (rx_full),
		.tx_empty_i   (tx_empty),
		.tx_data_i    (tx_word),
		.bus          (bus),
		.sda_oe_o     (sda_oe_o),
		.rx_push_o    (rx_push),
		.rx_data_o    (rx_word),
		.tx_pop_o     (tx_pop),
		.wstop_o      (wstop_o),
		.rstop_o      (rstop_o),
		.rerr_o       (rerr_o)
	);

	// ------------------------------------------------------------------------
	// Bus to system words
	// ------------------------------------------------------------------------
	word_fifo #(.DEPTH(`I2C_FIFO_DEPTH)) u_rx_fifo (
		.clk     (clk),
		.rst     (rst),
		.push_i  (rx_push),
		.pop_i   (rx_pop_i),
		.data_i  (rx_word),
		.data_o  (rx_data_o),
		.full_o  (rx_full),
		.empty_o (rx_empty_o)
	);

	// System words to bus
	word_fifo #(.DEPTH(`I2C_FIFO_DEPTH)) u_tx_fifo (
		.clk     (clk),
		.rst     (rst),
		.push_i  (tx_push_i),
		.pop_i   (tx_pop),
		.data_i  (tx_data_i),
		.data_o  (tx_word),
		.full_o  (tx_full_o),
		.empty_o (tx_empty)
	);

endmodule

// ==== logic/i2c_bus_if.sv ====
`timescale 1ns/1ps

interface i2c_bus_if;

	logic scl;        // Filtered SCL level
	logic sda;        // Filtered SDA level
	logic start;      // Start or repeated start
	logic stop;       // Stop condition
	logic scl_rise;
	logic scl_fall;

	modport sync (
		output scl, sda, start, stop, scl_rise, scl_fall
	);

	modport engine (
		input scl, sda, start, stop, scl_rise, scl_fall
	);

endinterface

// ==== logic/i2c_pin_sync.sv ====
`timescale 1ns/1ps
`include "i2c_bridge_cfg.svh"

module i2c_pin_sync (
	input  logic      clk,
	input  logic      rst,
	input  logic      scl_i,
	input  logic      sda_i,
	i2c_bus_if.sync   bus
);

	logic [`I2C_FILTER_LEN-1:0] scl_sh;
	logic [`I2C_FILTER_LEN-1:0] sda_sh;
	logic scl_q;       // Filtered levels
	logic sda_q;
	logic scl_d;       // Previous filtered levels
	logic sda_d;

	// ------------------------------------------------------------------------
	// Sampling and glitch filter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			scl_sh <= '1;  // Idle bus is high
			sda_sh <= '1;
			scl_q  <= 1'b1;
			sda_q  <= 1'b1;
			scl_d  <= 1'b1;
			sda_d  <= 1'b1;
		end else begin
			scl_sh <= {scl_sh[`I2C_FILTER_LEN-2:0], scl_i};
			sda_sh <= {sda_sh[`I2C_FILTER_LEN-2:0], sda_i};
			// Level moves only once every sample agrees
			if (&scl_sh)
				scl_q <= 1'b1;
			else if (~|scl_sh)
				scl_q <= 1'b0;
			if (&sda_sh)
				sda_q <= 1'b1;
			else if (~|sda_sh)
				sda_q <= 1'b0;
			scl_d <= scl_q;
			sda_d <= sda_q;
		end
	end

	assign bus.scl = scl_q;
	assign bus.sda = sda_q;

	// ------------------------------------------------------------------------
	// Bus events
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			bus.start    <= 1'b0;
			bus.stop     <= 1'b0;
			bus.scl_rise <= 1'b0;
			bus.scl_fall <= 1'b0;
		end else begin
			bus.start    <= scl_q && scl_d && sda_d && !sda_q;  // SDA falls, SCL high
			bus.stop     <= scl_q && scl_d && !sda_d && sda_q;  // SDA rises, SCL high
			bus.scl_rise <= scl_q && !scl_d;
			bus.scl_fall <= !scl_q && scl_d;
		end
	end

	a_start_stop_excl: assert property (@(posedge clk) disable iff (rst)
		!(bus.start && bus.stop))
		else $error("start and stop pulsed together");

endmodule

// ==== logic/i2c_slave_fsm.sv ====
`timescale 1ns/1ps
`include "i2c_bridge_cfg.svh"

module i2c_slave_fsm (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [6:0]             slave_addr_i,
	input  logic                   rx_full_i,
	input  logic                   tx_empty_i,
	input  i2c_bridge_pkg::word_t  tx_data_i,
	i2c_bus_if.engine              bus,
	output logic                   sda_oe_o,   // 1 pulls SDA low
	output logic                   rx_push_o,
	output i2c_bridge_pkg::word_t  rx_data_o,
	output logic                   tx_pop_o,
	output logic                   wstop_o,    // Write ended
	output logic                   rstop_o,    // Read ended by master NACK
	output logic                   rerr_o      // Released bit read back low
);

	localparam int MSB = `I2C_WORD_W - 1;

	i2c_bridge_pkg::i2c_state_e state;
	i2c_bridge_pkg::i2c_state_e state_nxt;
	i2c_bridge_pkg::word_t      shift_buf;
	logic [2:0] bit_cnt;
	logic [1:0] byte_cnt;
	logic start_seen;    // Start seen, waiting for first SCL fall
	logic rw_flg;        // 1 for a read transfer
	logic ack_r;         // Address was acknowledged
	logic mack;          // Master ACK bit, 0 is ACK
	logic get_8bit;
	logic addr_hit;
	logic addr_ack;
	logic rd_err;
	logic pop_req;

	assign get_8bit = bus.scl_fall && bit_cnt == 3'd7;
	assign addr_hit = shift_buf[7:1] == slave_addr_i || shift_buf[7:1] == 7'd0;

	// Write needs room, read needs data
	assign addr_ack = addr_hit && (shift_buf[0] ? !tx_empty_i : !rx_full_i);

	assign rd_err = state == i2c_bridge_pkg::RD_DATA && bus.scl_rise &&
			!sda_oe_o && !bus.sda;

	// Fetch a word at the read address ACK or after a fully acked word
	assign pop_req = bus.scl_rise && !bus.sda &&
			((state == i2c_bridge_pkg::ADDR_ACK && rw_flg && ack_r) ||
			 (state == i2c_bridge_pkg::RD_ACK && byte_cnt == 2'd0));

	assign rx_data_o = shift_buf;

	// ------------------------------------------------------------------------
	// State machine
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			state <= i2c_bridge_pkg::IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			i2c_bridge_pkg::IDLE:
				if (start_seen && bus.scl_fall)
					state_nxt = i2c_bridge_pkg::ADDR;
			i2c_bridge_pkg::ADDR:
				if (get_8bit)
					state_nxt = i2c_bridge_pkg::ADDR_ACK;
			i2c_bridge_pkg::ADDR_ACK:
				if (bus.scl_fall) begin
					if (!ack_r)
						state_nxt = i2c_bridge_pkg::IDLE;  // Silent until next start
					else if (rw_flg)
						state_nxt = i2c_bridge_pkg::RD_DATA;
					else
						state_nxt = i2c_bridge_pkg::WR_DATA;
				end
			i2c_bridge_pkg::WR_DATA:
				if (get_8bit)
					state_nxt = i2c_bridge_pkg::WR_ACK;
			i2c_bridge_pkg::WR_ACK:
				if (bus.scl_fall)
					state_nxt = i2c_bridge_pkg::WR_DATA;
			i2c_bridge_pkg::RD_DATA:
				if (rd_err)
					state_nxt = i2c_bridge_pkg::IDLE;
				else if (get_8bit)
					state_nxt = i2c_bridge_pkg::RD_ACK;
			i2c_bridge_pkg::RD_ACK:
				if (bus.scl_fall)
					state_nxt = mack ? i2c_bridge_pkg::IDLE : i2c_bridge_pkg::RD_DATA;
			default:
				state_nxt = i2c_bridge_pkg::IDLE;
		endcase
		// Start and stop win over everything
		if (bus.start || bus.stop)
			state_nxt = i2c_bridge_pkg::IDLE;
	end

	// ------------------------------------------------------------------------
	// Counters and flags
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst || state == i2c_bridge_pkg::IDLE)
			bit_cnt <= 3'd0;
		else if (bus.scl_fall && (state == i2c_bridge_pkg::ADDR ||
				state == i2c_bridge_pkg::WR_DATA || state == i2c_bridge_pkg::RD_DATA))
			bit_cnt <= bit_cnt + 3'd1;
	end

	always_ff @(posedge clk) begin
		if (rst || state == i2c_bridge_pkg::IDLE)
			byte_cnt <= 2'd0;
		else if (get_8bit && (state == i2c_bridge_pkg::WR_DATA ||
				state == i2c_bridge_pkg::RD_DATA))
			byte_cnt <= byte_cnt + 2'd1;  // Wraps once per word
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			start_seen <= 1'b0;
			rw_flg     <= 1'b0;
			ack_r      <= 1'b0;
			mack       <= 1'b1;
		end else begin
			if (bus.start)
				start_seen <= 1'b1;
			else if (bus.stop || bus.scl_fall)
				start_seen <= 1'b0;
			if (state == i2c_bridge_pkg::ADDR && get_8bit) begin
				rw_flg <= shift_buf[0];
				ack_r  <= addr_ack;
			end
			if (state == i2c_bridge_pkg::RD_ACK && bus.scl_rise)
				mack <= bus.sda;
		end
	end

	// ------------------------------------------------------------------------
	// SDA drive
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst || state_nxt == i2c_bridge_pkg::IDLE)
			sda_oe_o <= 1'b0;
		else if (state == i2c_bridge_pkg::ADDR && get_8bit)
			sda_oe_o <= addr_ack;
		else if (state == i2c_bridge_pkg::ADDR_ACK && bus.scl_fall)
			sda_oe_o <= rw_flg && !shift_buf[MSB];   // First read bit or release
		else if (state == i2c_bridge_pkg::WR_DATA && get_8bit)
			sda_oe_o <= 1'b1;                        // Data ACK
		else if (state == i2c_bridge_pkg::WR_ACK && bus.scl_fall)
			sda_oe_o <= 1'b0;
		else if (state == i2c_bridge_pkg::RD_DATA && get_8bit)
			sda_oe_o <= 1'b0;                        // Let the master answer
		else if ((state == i2c_bridge_pkg::RD_DATA || state == i2c_bridge_pkg::RD_ACK) &&
				bus.scl_fall)
			sda_oe_o <= !shift_buf[MSB];
	end

	// Shift buffer, also the received word
	always_ff @(posedge clk) begin
		if (tx_pop_o)
			shift_buf <= tx_data_i;
		else if (bus.scl_rise) begin
			if (state == i2c_bridge_pkg::RD_DATA)
				shift_buf <= {shift_buf[MSB-1:0], 1'b0};
			else if (state == i2c_bridge_pkg::ADDR || state == i2c_bridge_pkg::WR_DATA)
				shift_buf <= {shift_buf[MSB-1:0], bus.sda};
		end
	end

	// ------------------------------------------------------------------------
	// FIFO strobes and status pulses
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_push_o <= 1'b0;
			tx_pop_o  <= 1'b0;
			wstop_o   <= 1'b0;
			rstop_o   <= 1'b0;
			rerr_o    <= 1'b0;
		end else begin
			rx_push_o <= state == i2c_bridge_pkg::WR_DATA && get_8bit && byte_cnt == 2'd3;
			tx_pop_o  <= pop_req;
			wstop_o   <= state == i2c_bridge_pkg::WR_DATA && (bus.start || bus.stop);
			rstop_o   <= state == i2c_bridge_pkg::RD_ACK && bus.scl_fall && mack;
			rerr_o    <= rd_err;
		end
	end

	a_idle_released: assert property (@(posedge clk) disable iff (rst)
		state == i2c_bridge_pkg::IDLE |-> !sda_oe_o)
		else $error("SDA driven while idle");

	a_rx_no_overflow: assert property (@(posedge clk) disable iff (rst)
		rx_push_o |-> !rx_full_i)
		else $error("push into full receive FIFO");

	a_tx_no_underflow: assert property (@(posedge clk) disable iff (rst)
		tx_pop_o |-> !tx_empty_i)
		else $error("pop from empty transmit FIFO");

endmodule

// ==== logic/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   push_i,
	input  logic                   pop_i,
	input  i2c_bridge_pkg::word_t  data_i,
	output i2c_bridge_pkg::word_t  data_o,
	output logic                   full_o,
	output logic                   empty_o
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	i2c_bridge_pkg::word_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic do_push;
	logic do_pop;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // Both or neither
			endcase
		end
	end

	assign data_o  = mem[rd_ptr];  // Head shows while not empty
	assign full_o  = count == (AW+1)'(DEPTH);
	assign empty_o = count == '0;

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		push_i |-> !full_o)
		else $error("push while full");

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		pop_i |-> !empty_o)
		else $error("pop while empty");

endmodule
